// ==== include/rvCore_defines.svh ====
`ifndef RVCORE_DEFINES_SVH
`define RVCORE_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////

`define XLEN        32  // data path
`define REG_ADDR_W  5   // x0..x31
`define IMEM_ADDR_W 11  // instruction word address, 2k words

//////////////////////////////////////////////////////////////////////
// opcodes of the supported subset
//////////////////////////////////////////////////////////////////////

`define OP_LOAD   7'b0000011 // lw
`define OP_STORE  7'b0100011 // sw
`define OP_RTYPE  7'b0110011 // add sub and or slt
`define OP_BRANCH 7'b1100011 // beq
`define OP_IMM    7'b0010011 // addi
`define OP_JAL    7'b1101111 // jal

//////////////////////////////////////////////////////////////////////
// alu operation codes
//////////////////////////////////////////////////////////////////////

`define ALU_ADD 3'b000
`define ALU_SUB 3'b001
`define ALU_AND 3'b010
`define ALU_OR  3'b011
`define ALU_SLT 3'b101 // unsigned compare

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== verilog/rvPkg.sv ====
`include "rvCore_defines.svh"

package rvPkg;

    //////////////////////////////////////////////////////////////////
    // instruction formats, msb first
    //////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7; // bit 5 picks sub
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi; // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo; // imm[4:0]
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    // one fetched word, viewed through each format
    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        jTypeT j;
    } instrT;

    //////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {immI, immS, immB, immJ} immSrcT;

    typedef enum logic [1:0] {resAlu, resMem, resPc4} resultSrcT; // writeback source

    typedef enum logic [2:0] {
        aluAdd = `ALU_ADD,
        aluSub = `ALU_SUB,
        aluAnd = `ALU_AND,
        aluOr  = `ALU_OR,
        aluSlt = `ALU_SLT
    } aluCtrlT;

    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
        logic      memWrite;
        logic      jump;
        logic      branch;
        aluCtrlT   aluCtrl;
        logic      aluSrc; // 1 = immediate operand
    } exCtrlT;

    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
        logic      memWrite;
    } memCtrlT;

    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
    } wbCtrlT;

endpackage

// ==== verilog/rvStageIf.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

//////////////////////////////////////////////////////////////////////
// decode -> execute
//////////////////////////////////////////////////////////////////////

interface decExIf;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       pcPlus4;
    logic [`XLEN-1:0]       rd1;     // rs1 value
    logic [`XLEN-1:0]       rd2;     // rs2 value
    logic [`XLEN-1:0]       immExt;
    logic [`REG_ADDR_W-1:0] rd;      // destination index
    rvPkg::exCtrlT          ctrl;

    modport source (output pc, pcPlus4, rd1, rd2, immExt, rd, ctrl);
    modport sink   (input  pc, pcPlus4, rd1, rd2, immExt, rd, ctrl);
endinterface

//////////////////////////////////////////////////////////////////////
// execute -> memory
//////////////////////////////////////////////////////////////////////

interface exMemIf;
    logic [`XLEN-1:0]       pcPlus4;
    logic [`XLEN-1:0]       aluResult; // also the data address
    logic [`XLEN-1:0]       writeData;
    logic [`REG_ADDR_W-1:0] rd;
    rvPkg::memCtrlT         ctrl;

    modport source (output pcPlus4, aluResult, writeData, rd, ctrl);
    modport sink   (input  pcPlus4, aluResult, writeData, rd, ctrl);
endinterface

//////////////////////////////////////////////////////////////////////
// memory -> writeback
//////////////////////////////////////////////////////////////////////

interface memWbIf;
    logic [`XLEN-1:0]       pcPlus4;   // link value for jal
    logic [`XLEN-1:0]       aluResult;
    logic [`XLEN-1:0]       readData;
    logic [`REG_ADDR_W-1:0] rd;
    rvPkg::wbCtrlT          ctrl;

    modport source (output pcPlus4, aluResult, readData, rd, ctrl);
    modport sink   (input  pcPlus4, aluResult, readData, rd, ctrl);
endinterface

// ==== verilog/fetchStage.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module fetchStage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pcSrc,    // taken branch or jal in execute
    input  logic [`XLEN-1:0]        pcTarget,
    input  logic [`XLEN-1:0]        imemData,
    output logic [`IMEM_ADDR_W-1:0] imemAddr,
    output rvPkg::instrT            instr,
    output logic [`XLEN-1:0]        pc,
    output logic [`XLEN-1:0]        pcPlus4
);

    logic [`XLEN-1:0] pcF;
    logic [`XLEN-1:0] pcPlus4F;
    logic [`XLEN-1:0] pcNext;

    assign pcPlus4F = pcF + 32'd4;
    assign pcNext   = pcSrc ? pcTarget : pcPlus4F; // redirect wins

    always_ff @(posedge clk or posedge rst) begin
        if (rst) pcF <= `RESET_PC;
        else     pcF <= pcNext;
    end

    // byte pc -> word address, same cycle
    assign imemAddr = pcF[`IMEM_ADDR_W+1:2];

    //////////////////////////////////////////////////////////////////
    // fetch/decode register
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) instr <= '0; // opcode 0 decodes to no control
        else     instr <= imemData;
    end

    always_ff @(posedge clk) begin
        pc      <= pcF;
        pcPlus4 <= pcPlus4F;
    end

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] ra1,
    input  logic [`REG_ADDR_W-1:0] ra2,
    output logic [`XLEN-1:0]       rd1,
    output logic [`XLEN-1:0]       rd2,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] wa,
    input  logic [`XLEN-1:0]       wd
);

    logic [`XLEN-1:0] regs [1:31]; // x0 is not stored

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // write-before-read: a same-cycle write shows up on the read port
    always_comb begin
        if (ra1 == '0)                rd1 = '0;
        else if (we && (wa == ra1))   rd1 = wd;  // bypass
        else                          rd1 = regs[ra1];
        if (ra2 == '0)                rd2 = '0;
        else if (we && (wa == ra2))   rd2 = wd;
        else                          rd2 = regs[ra2];
    end

endmodule

// ==== verilog/decodeWriteback.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module decodeWriteback (
    input  logic             clk,
    input  logic             rst,
    input  rvPkg::instrT     instr,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] pcPlus4,
    decExIf.source           ex,
    memWbIf.sink             wb
);

    logic [6:0]         opcode;
    logic               regWriteD;
    rvPkg::resultSrcT   resultSrcD;
    logic               memWriteD;
    logic               jumpD;
    logic               branchD;
    logic               aluSrcD;
    rvPkg::immSrcT      immSrcD;
    rvPkg::aluCtrlT     aluCtrlD;
    rvPkg::exCtrlT      ctrlD;
    logic [`XLEN-1:0]   immExtD;
    logic [`XLEN-1:0]   rd1D;
    logic [`XLEN-1:0]   rd2D;
    logic [`XLEN-1:0]   resultW;

    assign opcode = instr.r.opcode; // same position in every format

    //////////////////////////////////////////////////////////////////
    // main decoder
    //////////////////////////////////////////////////////////////////

    always_comb begin
        regWriteD  = 1'b0;
        resultSrcD = rvPkg::resAlu;
        memWriteD  = 1'b0;
        jumpD      = 1'b0;
        branchD    = 1'b0;
        aluSrcD    = 1'b0;
        immSrcD    = rvPkg::immI;
        case (opcode)
            `OP_LOAD: begin
                regWriteD  = 1'b1;
                resultSrcD = rvPkg::resMem;
                aluSrcD    = 1'b1;              // base + offset
            end
            `OP_STORE: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immSrcD   = rvPkg::immS;
            end
            `OP_RTYPE:  regWriteD = 1'b1;
            `OP_BRANCH: begin
                branchD = 1'b1;                 // compare by subtract
                immSrcD = rvPkg::immB;
            end
            `OP_IMM: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
            end
            `OP_JAL: begin
                regWriteD  = 1'b1;
                resultSrcD = rvPkg::resPc4;     // link register gets pc+4
                jumpD      = 1'b1;
                immSrcD    = rvPkg::immJ;
            end
            default: ;                          // unknown -> bubble
        endcase
    end

    // alu decoder
    always_comb begin
        case (opcode)
            `OP_BRANCH:         aluCtrlD = rvPkg::aluSub;
            `OP_RTYPE, `OP_IMM: begin
                case (instr.r.funct3)
                    3'b000:  aluCtrlD = (opcode == `OP_RTYPE && instr.r.funct7[5]) ?
                                        rvPkg::aluSub : rvPkg::aluAdd; // sub only for R
                    3'b010:  aluCtrlD = rvPkg::aluSlt;
                    3'b110:  aluCtrlD = rvPkg::aluOr;
                    3'b111:  aluCtrlD = rvPkg::aluAnd;
                    default: aluCtrlD = rvPkg::aluAdd;
                endcase
            end
            default:            aluCtrlD = rvPkg::aluAdd; // lw, sw address
        endcase
    end

    assign ctrlD = '{regWrite: regWriteD, resultSrc: resultSrcD, memWrite: memWriteD,
                     jump: jumpD, branch: branchD, aluCtrl: aluCtrlD, aluSrc: aluSrcD};

    // immediate extension
    always_comb begin
        case (immSrcD)
            rvPkg::immI: immExtD = {{20{instr.i.imm[11]}}, instr.i.imm};
            rvPkg::immS: immExtD = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            rvPkg::immB: immExtD = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10to5,
                                    instr.b.imm4to1, 1'b0};
            default:     immExtD = {{12{instr.j.imm20}}, instr.j.imm19to12, instr.j.imm11,
                                    instr.j.imm10to1, 1'b0};
        endcase
    end

    //////////////////////////////////////////////////////////////////
    // writeback and register file
    //////////////////////////////////////////////////////////////////

    always_comb begin
        case (wb.ctrl.resultSrc)
            rvPkg::resAlu: resultW = wb.aluResult;
            rvPkg::resMem: resultW = wb.readData;
            rvPkg::resPc4: resultW = wb.pcPlus4;
            default:       resultW = '0;
        endcase
    end

    regFile rf (
        .clk (clk),
        .rst (rst),
        .ra1 (instr.r.rs1),
        .ra2 (instr.r.rs2),
        .rd1 (rd1D),
        .rd2 (rd2D),
        .we  (wb.ctrl.regWrite),
        .wa  (wb.rd),
        .wd  (resultW)
    );

    // decode/execute register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) ex.ctrl <= '0;
        else     ex.ctrl <= ctrlD;
    end

    always_ff @(posedge clk) begin
        ex.pc      <= pc;
        ex.pcPlus4 <= pcPlus4;
        ex.rd1     <= rd1D;
        ex.rd2     <= rd2D;
        ex.immExt  <= immExtD;
        ex.rd      <= instr.r.rd;
    end

endmodule

// ==== verilog/executeStage.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module executeStage (
    input  logic             clk,
    input  logic             rst,
    output logic             pcSrc,    // redirect fetch
    output logic [`XLEN-1:0] pcTarget,
    decExIf.sink             ex,
    exMemIf.source           mem
);

    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluResult;
    logic             zero;

    //////////////////////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////////////////////

    assign srcA = ex.rd1;
    assign srcB = ex.ctrl.aluSrc ? ex.immExt : ex.rd2; // imm for addi, lw, sw

    always_comb begin
        case (ex.ctrl.aluCtrl)
            rvPkg::aluAdd: aluResult = srcA + srcB;
            rvPkg::aluSub: aluResult = srcA - srcB;
            rvPkg::aluAnd: aluResult = srcA & srcB;
            rvPkg::aluOr:  aluResult = srcA | srcB;
            rvPkg::aluSlt: aluResult = (srcA < srcB) ? 32'd1 : 32'd0; // unsigned
            default:       aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0); // beq equal when a - b is 0

    // branch / jump resolution
    assign pcSrc    = (zero & ex.ctrl.branch) | ex.ctrl.jump;
    assign pcTarget = ex.pc + ex.immExt;

    //////////////////////////////////////////////////////////////////
    // execute/memory register
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem.ctrl <= '0;
        end else begin
            mem.ctrl <= '{regWrite:  ex.ctrl.regWrite,
                          resultSrc: ex.ctrl.resultSrc,
                          memWrite:  ex.ctrl.memWrite};
        end
    end

    always_ff @(posedge clk) begin
        mem.pcPlus4   <= ex.pcPlus4;
        mem.aluResult <= aluResult;
        mem.writeData <= ex.rd2;   // store data, never the imm
        mem.rd        <= ex.rd;
    end

endmodule

// ==== verilog/memoryStage.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module memoryStage (
    input  logic             clk,
    input  logic             rst,
    exMemIf.sink             mem,
    memWbIf.source           wb,
    input  logic [`XLEN-1:0] dmemReadData,  // combinational answer
    output logic             dmemWrite,
    output logic [`XLEN-1:0] dmemAddr,
    output logic [`XLEN-1:0] dmemWriteData
);

    // data memory port straight from the ex/mem register
    assign dmemWrite     = mem.ctrl.memWrite;
    assign dmemAddr      = mem.aluResult;
    assign dmemWriteData = mem.writeData;

    //////////////////////////////////////////////////////////////////
    // memory/writeback register
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) wb.ctrl <= '0;
        else     wb.ctrl <= rvPkg::wbCtrlT'{regWrite:  mem.ctrl.regWrite,
                                            resultSrc: mem.ctrl.resultSrc};
    end

    always_ff @(posedge clk) begin
        wb.readData  <= dmemReadData;  // lw result
        wb.aluResult <= mem.aluResult;
        wb.pcPlus4   <= mem.pcPlus4;
        wb.rd        <= mem.rd;
    end

endmodule

// ==== verilog/rvCore.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module rvCore (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`XLEN-1:0]        imemData,
    output logic [`IMEM_ADDR_W-1:0] imemAddr,
    input  logic [`XLEN-1:0]        dmemReadData,
    output logic                    dmemWrite,
    output logic [`XLEN-1:0]        dmemAddr,
    output logic [`XLEN-1:0]        dmemWriteData
);

    rvPkg::instrT     instrD;   // fetch -> decode
    logic [`XLEN-1:0] pcD;
    logic [`XLEN-1:0] pcPlus4D;
    logic             pcSrcE;   // execute -> fetch
    logic [`XLEN-1:0] pcTargetE;

    ////////////////////////////////////////////////////////////////////
    // stage links
    ////////////////////////////////////////////////////////////////////

    decExIf decEx ();
    exMemIf exMem ();
    memWbIf memWb ();

    fetchStage fetch (
        .clk      (clk),
        .rst      (rst),
        .pcSrc    (pcSrcE),
        .pcTarget (pcTargetE),
        .imemData (imemData),
        .imemAddr (imemAddr),
        .instr    (instrD),
        .pc       (pcD),
        .pcPlus4  (pcPlus4D)
    );

    decodeWriteback decode (.clk(clk), .rst(rst), .instr(instrD), .pc(pcD),
                            .pcPlus4(pcPlus4D), .ex(decEx), .wb(memWb));

    executeStage execute (.clk(clk), .rst(rst), .pcSrc(pcSrcE), .pcTarget(pcTargetE),
                          .ex(decEx), .mem(exMem));

    memoryStage memory (
        .clk           (clk),
        .rst           (rst),
        .mem           (exMem),
        .wb            (memWb),   // closes the loop to writeback
        .dmemReadData  (dmemReadData),
        .dmemWrite     (dmemWrite),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData)
    );

endmodule

// ==== tb/rvCoreAssertions.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module rvCoreAssertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    dmemWrite,
    input logic [`XLEN-1:0]        dmemAddr,
    input logic [`IMEM_ADDR_W-1:0] imemAddr
);

    int failCount = 0; // read by the testbench at the end

    // no store may leave the core while reset is held
    noStoreInReset: assert property (@(posedge clk) rst |-> !dmemWrite)
        else begin
            failCount++;
            $error("dmemWrite high while rst is asserted");
        end

    alignedStore: assert property (@(posedge clk) disable iff (rst)
                                   dmemWrite |-> (dmemAddr[1:0] == 2'b00))
        else begin
            failCount++;
            $error("store address 0x%h is not word aligned", dmemAddr);
        end

    // first fetch after release comes from the reset pc
    fetchFromReset: assert property (@(posedge clk) $fell(rst) |-> (imemAddr == '0))
        else begin
            failCount++;
            $error("imemAddr 0x%h is not zero in the first cycle after reset", imemAddr);
        end

endmodule

bind rvCore rvCoreAssertions protocolChecks (
    .clk       (clk),
    .rst       (rst),
    .dmemWrite (dmemWrite),
    .dmemAddr  (dmemAddr),
    .imemAddr  (imemAddr)
);

// ==== tb/rvCoreTb.sv ====
`timescale 1ns/1ps
`include "rvCore_defines.svh"

module rvCoreTb;

    localparam int          PROG_LEN    = 35;
    localparam int          CYCLE_LIMIT = PROG_LEN + 5 + 20; // table, reset, drain margin
    localparam logic [31:0] STORE_BASE  = 32'h0000_0100;     // held in x4

    typedef struct {
        rvPkg::instrT     instr;
        logic             expValid; // this instruction must store
        logic [`XLEN-1:0] expAddr;
        logic [`XLEN-1:0] expData;
    } stepT;

    logic                    clk;
    logic                    rst;
    logic [`XLEN-1:0]        imemData;
    logic [`IMEM_ADDR_W-1:0] imemAddr;
    logic [`XLEN-1:0]        dmemReadData;
    logic                    dmemWrite;
    logic [`XLEN-1:0]        dmemAddr;
    logic [`XLEN-1:0]        dmemWriteData;

    logic [`XLEN-1:0] imem [0:(1 << `IMEM_ADDR_W)-1];
    logic [`XLEN-1:0] dmem [0:255]; // 1 KiB, byte address bits 9:2
    stepT             prog [0:PROG_LEN-1];
    int               nSteps   = 0;
    int               storeIdx = 0; // stores seen so far
    int               cycles   = 0;
    int               expIdx [$];   // table rows that store, in order

    rvCore DUT (
        .clk           (clk),
        .rst           (rst),
        .imemData      (imemData),
        .imemAddr      (imemAddr),
        .dmemReadData  (dmemReadData),
        .dmemWrite     (dmemWrite),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData)
    );

    //////////////////////////////////////////////////////////////////////
    // clock and memory models
    //////////////////////////////////////////////////////////////////////

    always #4 clk = ~clk; // 8 ns period

    assign imemData     = imem[imemAddr];      // combinational fetch
    assign dmemReadData = dmem[dmemAddr[9:2]];

    always @(posedge clk) begin
        if (dmemWrite) dmem[dmemAddr[9:2]] <= dmemWriteData;
    end

    // preset data word, every index bit shows up
    function automatic logic [`XLEN-1:0] fillWord(input logic [7:0] idx);
        return 32'h1357_9BDF ^ {4{idx}};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // instruction encoders
    //////////////////////////////////////////////////////////////////////

    function automatic rvPkg::instrT encR(input logic [2:0] f3, input logic isSub,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        rvPkg::instrT w;
        w.r = '{funct7: {1'b0, isSub, 5'b0}, rs2: rs2, rs1: rs1, funct3: f3, rd: rd,
                opcode: `OP_RTYPE};
        return w;
    endfunction

    function automatic rvPkg::instrT encI(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        rvPkg::instrT w;
        w.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: op};
        return w;
    endfunction

    function automatic rvPkg::instrT encS(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        rvPkg::instrT w;
        w.s = '{immHi: imm[11:5], rs2: rs2, rs1: rs1, funct3: 3'b010, immLo: imm[4:0],
                opcode: `OP_STORE};
        return w;
    endfunction

    function automatic rvPkg::instrT encB(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [12:0] off);
        rvPkg::instrT w;
        w.b = '{imm12: off[12], imm10to5: off[10:5], rs2: rs2, rs1: rs1, funct3: 3'b000,
                imm4to1: off[4:1], imm11: off[11], opcode: `OP_BRANCH};
        return w;
    endfunction

    function automatic rvPkg::instrT encJ(input logic [4:0] rd, input logic [20:0] off);
        rvPkg::instrT w;
        w.j = '{imm20: off[20], imm10to1: off[10:1], imm11: off[11],
                imm19to12: off[19:12], rd: rd, opcode: `OP_JAL};
        return w;
    endfunction

    function automatic rvPkg::instrT nop();
        return encI(`OP_IMM, 3'b000, 5'd0, 5'd0, 12'd0); // addi x0, x0, 0
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////////////////////////

    task automatic addStep(input rvPkg::instrT w, input logic v,
                           input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] d);
        prog[nSteps] = '{instr: w, expValid: v, expAddr: a, expData: d};
        nSteps++;
    endtask

    task automatic addInstr(input rvPkg::instrT w);
        addStep(w, 1'b0, '0, '0);
    endtask

    // sw rs2, off(x4), address is base plus offset
    task automatic addStore(input logic [4:0] rs2, input logic [11:0] off,
                            input logic [`XLEN-1:0] data);
        addStep(encS(rs2, 5'd4, off), 1'b1, STORE_BASE + {20'd0, off}, data);
    endtask

    task automatic buildProgram();
        addInstr(encI(`OP_IMM, 3'b000, 5'd1, 5'd0, 12'h123));
        addInstr(encI(`OP_IMM, 3'b000, 5'd3, 5'd0, 12'h0F0));
        addInstr(encI(`OP_IMM, 3'b000, 5'd2, 5'd0, 12'hFFB));  // -5
        addInstr(encI(`OP_IMM, 3'b000, 5'd4, 5'd0, 12'h100));  // store base
        addInstr(encR(3'b000, 1'b0, 5'd5, 5'd1, 5'd3));         // add
        addInstr(encR(3'b000, 1'b1, 5'd6, 5'd1, 5'd3));         // sub
        addInstr(encR(3'b111, 1'b0, 5'd7, 5'd1, 5'd3));         // and
        addStore(5'd1, 12'd0, 32'h0000_0123);
        addStore(5'd2, 12'd4, 32'hFFFF_FFFB);                   // sign extended
        addInstr(encR(3'b110, 1'b0, 5'd8, 5'd1, 5'd3));         // or
        addInstr(encR(3'b010, 1'b0, 5'd9, 5'd2, 5'd1));         // slt, fffffffb vs 123
        addInstr(encR(3'b010, 1'b0, 5'd10, 5'd1, 5'd2));
        addStore(5'd5, 12'd8, 32'h0000_0213);                   // 123 + f0
        addStore(5'd6, 12'd12, 32'h0000_0033);                  // 123 - f0
        addStore(5'd7, 12'd16, 32'h0000_0020);
        addStore(5'd8, 12'd20, 32'h0000_01F3);
        addStore(5'd9, 12'd24, 32'h0000_0000);                  // unsigned, not less
        addStore(5'd10, 12'd28, 32'h0000_0001);
        addInstr(encI(`OP_LOAD, 3'b010, 5'd11, 5'd0, 12'h040)); // lw x11, 0x40(x0)
        addInstr(nop());
        addInstr(nop());
        addInstr(nop());
        addStore(5'd11, 12'd32, fillWord(8'h10));
        addInstr(encB(5'd1, 5'd3, 13'd12));                     // not taken
        addStore(5'd1, 12'd36, 32'h0000_0123);
        addInstr(encB(5'd1, 5'd1, 13'd16));                     // taken, to row 29
        addStore(5'd3, 12'd40, 32'h0000_00F0);                  // shadow slot
        addStore(5'd2, 12'd44, 32'hFFFF_FFFB);                  // shadow slot
        addStep(encS(5'd1, 5'd4, 12'd48), 1'b0, '0, '0);        // skipped
        addInstr(encJ(5'd12, 21'd16));                          // row 29, to row 33
        addInstr(encI(`OP_IMM, 3'b000, 5'd13, 5'd0, 12'h055));  // shadow slot
        addInstr(nop());
        addStep(encS(5'd1, 5'd4, 12'd52), 1'b0, '0, '0);        // skipped
        addStore(5'd12, 12'd56, 32'h0000_0078);                 // link = 29*4 + 4
        addStore(5'd13, 12'd60, 32'h0000_0055);
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkWord(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkImemAddr(input logic [`IMEM_ADDR_W-1:0] got,
                                 input logic [`IMEM_ADDR_W-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("ERROR imemAddr: got 0x%h, expected 0x%h", got, exp));
        end
    endtask

    // sample mid cycle, outputs settled
    always @(negedge clk) begin
        if (rst) begin
            checkImemAddr(imemAddr, '0);
            if (dmemWrite !== 1'b0) failRun("a store was issued while reset was active");
        end else if (dmemWrite) begin
            if (storeIdx >= expIdx.size()) begin
                failRun("the core issued a store that the program does not expect");
            end else begin
                checkWord("dmemAddr", dmemAddr, prog[expIdx[storeIdx]].expAddr);
                checkWord("dmemWriteData", dmemWriteData, prog[expIdx[storeIdx]].expData);
                storeIdx++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            failRun("the run timed out before all expected stores were seen");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        buildProgram();
        // filler is addi x0, x0, index
        for (int a = 0; a < (1 << `IMEM_ADDR_W); a++) begin
            imem[a] = encI(`OP_IMM, 3'b000, 5'd0, 5'd0, a[11:0]);
        end
        for (int a = 0; a < 256; a++) dmem[a] = fillWord(a[7:0]);
        for (int k = 0; k < nSteps; k++) begin
            imem[k] = prog[k].instr;
            if (prog[k].expValid) expIdx.push_back(k);
        end
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        for (int e = 0; e < expIdx.size(); e++) begin
            wait (storeIdx > e); // store e checked by the monitor
        end
        repeat (3) @(negedge clk); // window for a stray store
        if (DUT.protocolChecks.failCount == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("protocol assertions failed %0d times", DUT.protocolChecks.failCount);
            $display("*** TEST FAILED ***");
            $fatal(1, "run ended with assertion failures");
        end
    end

endmodule

// ==== compile.f ====
+incdir+include
verilog/rvPkg.sv
verilog/rvStageIf.sv
verilog/fetchStage.sv
verilog/regFile.sv
verilog/decodeWriteback.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/rvCore.sv
tb/rvCoreAssertions.sv
tb/rvCoreTb.sv

// ==== Bender.yml ====
package:
  name: rvcore

export_include_dirs:
  - include

sources:
  - files:
      - verilog/rvPkg.sv
      - verilog/rvStageIf.sv
      - verilog/fetchStage.sv
      - verilog/regFile.sv
      - verilog/decodeWriteback.sv
      - verilog/executeStage.sv
      - verilog/memoryStage.sv
      - verilog/rvCore.sv
  - target: test
    files:
      - tb/rvCoreAssertions.sv
      - tb/rvCoreTb.sv
